// File: Makefile
TOP = tbProc

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): proc.f src/*.sv src/*.svh testbench/*.sv
	verilator --binary --timing -f proc.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only --timing -f proc.f --top-module proc

clean:
	rm -rf obj_dir sim.log

// File: proc.f
+incdir+src
src/procPkg.sv
src/pipeIfs.sv
src/fetch.sv
src/decode.sv
src/execute.sv
src/memory.sv
src/proc.sv
testbench/tbProc.sv

// File: src/decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "proc_settings.svh"

module decode (
   input  wire                 clk,
   input  wire                 rst,
   input  procPkg::instrT      instrD,
   input  wire [15:0]          pcIncD,
   input  wire                 validD,
   input  wire                 redirect,
   input  wire                 wbValid,
   input  wire                 wbRegWrt,
   input  wire [2:0]           wbRd,
   input  wire [15:0]          wbData,
   output logic                stall,
   output logic                err,
   decodeExecIf.src            dx
);

   logic [15:0]      regs [`PROC_NREGS];
   procPkg::opcodeT  opcode;
   procPkg::ctrlT    ctrl;
   logic [2:0]       rsSel;
   logic [2:0]       rtSel;
   logic [2:0]       rdSel;
   logic [15:0]      imm;
   logic             illegal;
   logic             wbHit;
   logic             accept;
   logic             haltSeen;

   assign opcode = instrD.rForm.opcode;
   assign rsSel  = instrD.rForm.rs;
   // A store's data register sits in the same bits as rt
   assign rtSel  = instrD.rForm.rt;

   always_comb begin
      ctrl       = '0;
      ctrl.aluOp = procPkg::aluAdd;
      rdSel      = instrD.rForm.rd;
      imm        = {{11{instrD.iForm.imm[4]}}, instrD.iForm.imm};
      illegal    = 1'b0;
      case (opcode)
         procPkg::opAlu: begin
            ctrl.aluOp  = instrD.rForm.func;
            ctrl.regWrt = 1'b1;
         end
         procPkg::opAddi: begin
            ctrl.useImm = 1'b1;
            ctrl.regWrt = 1'b1;
            rdSel       = instrD.iForm.rd;
         end
         procPkg::opLbi: begin
            ctrl.passImm = 1'b1;
            ctrl.regWrt  = 1'b1;
            rdSel        = instrD.bForm.rs;
            imm          = {{8{instrD.bForm.imm[7]}}, instrD.bForm.imm};
         end
         procPkg::opLd: begin
            ctrl.useImm  = 1'b1;
            ctrl.regWrt  = 1'b1;
            ctrl.memRead = 1'b1;
            rdSel        = instrD.iForm.rd;
         end
         procPkg::opSt: begin
            ctrl.useImm = 1'b1;
            ctrl.memWrt = 1'b1;
         end
         procPkg::opBeqz, procPkg::opBnez: begin
            ctrl.branch    = 1'b1;
            ctrl.brNotZero = (opcode == procPkg::opBnez);
            imm            = {{8{instrD.bForm.imm[7]}}, instrD.bForm.imm};
         end
         procPkg::opHalt: ctrl.halt = 1'b1;
         default:         illegal   = 1'b1;
      endcase
   end

   // Load in execute feeding this instruction
   assign stall = validD && dx.valid && dx.ctrl.memRead &&
                  ((dx.rd == rsSel) || (dx.rd == rtSel));

   // Nothing past a HALT is allowed into execute
   assign accept = validD && !stall && !redirect && !haltSeen;
   assign wbHit  = wbValid && wbRegWrt;

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `PROC_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wbHit) begin
         regs[wbRd] <= wbData;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         dx.valid <= 1'b0;
         haltSeen <= 1'b0;
         err      <= 1'b0;
      end else begin
         dx.valid <= accept;
         haltSeen <= haltSeen || (accept && ctrl.halt);
         err      <= err || (accept && illegal);
      end
   end

   always_ff @(posedge clk) begin
      dx.ctrl  <= ctrl;
      dx.rs    <= rsSel;
      dx.rt    <= rtSel;
      dx.rd    <= rdSel;
      dx.opA   <= (wbHit && wbRd == rsSel) ? wbData : regs[rsSel];
      dx.opB   <= (wbHit && wbRd == rtSel) ? wbData : regs[rtSel];
      dx.imm   <= imm;
      dx.pcInc <= pcIncD;
   end

endmodule

`default_nettype wire

// File: src/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
   input  wire          clk,
   input  wire          rst,
   decodeExecIf.dst     dx,
   input  wire [2:0]    memRd,
   input  wire [15:0]   memResult,
   input  wire          memRegWrt,
   input  wire          memValid,
   input  wire          wbValid,
   input  wire          wbRegWrt,
   input  wire [2:0]    wbRd,
   input  wire [15:0]   wbData,
   output logic         redirect,
   output logic [15:0]  target,
   execMemIf.src        em
);

   logic        memHit;
   logic        wbHit;
   logic [15:0] srcA;
   logic [15:0] srcB;
   logic [15:0] aluB;
   logic [15:0] aluOut;
   logic [15:0] result;

   // memRegWrt is already low for loads
   assign memHit = memValid && memRegWrt;
   assign wbHit  = wbValid && wbRegWrt;

   // Newest producer wins
   assign srcA = (memHit && memRd == dx.rs) ? memResult :
                 (wbHit && wbRd == dx.rs)   ? wbData    : dx.opA;
   assign srcB = (memHit && memRd == dx.rt) ? memResult :
                 (wbHit && wbRd == dx.rt)   ? wbData    : dx.opB;

   assign aluB = dx.ctrl.useImm ? dx.imm : srcB;

   always_comb begin
      case (dx.ctrl.aluOp)
         procPkg::aluAdd: aluOut = srcA + aluB;
         procPkg::aluSub: aluOut = srcA - aluB;
         procPkg::aluAnd: aluOut = srcA & aluB;
         default:         aluOut = srcA ^ aluB;
      endcase
   end

   assign result = dx.ctrl.passImm ? dx.imm : aluOut;

   // BEQZ taken on zero, BNEZ on nonzero
   assign redirect = dx.valid && dx.ctrl.branch &&
                     ((srcA == 16'd0) ^ dx.ctrl.brNotZero);
   assign target   = dx.pcInc + dx.imm;

   always_ff @(posedge clk) begin
      if (rst) begin
         em.valid <= 1'b0;
      end else begin
         em.valid <= dx.valid;
      end
   end

   always_ff @(posedge clk) begin
      em.ctrl      <= dx.ctrl;
      em.rd        <= dx.rd;
      em.result    <= result;
      em.storeData <= srcB;
   end

endmodule

`default_nettype wire

// File: src/fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "proc_settings.svh"

module fetch (
   input  wire                      clk,
   input  wire                      rst,
   input  wire                      imemWrEn,
   input  wire [`PROC_IMEM_AW-1:0]  imemAddr,
   input  wire [15:0]               imemData,
   input  wire                      stall,
   input  wire                      halted,
   input  wire                      redirect,
   input  wire [15:0]               target,
   output procPkg::instrT           instrD,
   output logic [15:0]              pcIncD,
   output logic                     validD
);

   logic [15:0]              imem [2**`PROC_IMEM_AW];
   logic [`PROC_IMEM_AW-1:0] pc;
   logic [`PROC_IMEM_AW-1:0] pcPlusOne;

   assign pcPlusOne = pc + 1'b1;

   // Program load happens only while the core is held in reset
   always_ff @(posedge clk) begin
      if (rst && imemWrEn) begin
         imem[imemAddr] <= imemData;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc     <= '0;
         validD <= 1'b0;
      end else if (redirect) begin
         pc     <= target[`PROC_IMEM_AW-1:0];
         validD <= 1'b0;
      end else if (!stall) begin
         if (!halted) begin
            pc <= pcPlusOne;
         end
         validD <= !halted;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         instrD <= imem[pc];
         pcIncD <= {{(16-`PROC_IMEM_AW){1'b0}}, pcPlusOne};
      end
   end

endmodule

`default_nettype wire

// File: src/memory.sv
`timescale 1ns/1ps
`default_nettype none
`include "proc_settings.svh"

module memory (
   input  wire                      clk,
   input  wire                      rst,
   execMemIf.dst                    em,
   output logic [2:0]               memRd,
   output logic [15:0]              memResult,
   output logic                     memRegWrt,
   output logic                     memValid,
   output logic                     wbValid,
   output logic                     wbRegWrt,
   output logic [2:0]               wbRd,
   output logic [15:0]              wbData,
   output logic                     storeValid,
   output logic [`PROC_DMEM_AW-1:0] storeAddr,
   output logic [15:0]              storeData,
   output logic                     halted
);

   logic [15:0] dmem [2**`PROC_DMEM_AW];
   logic [15:0] loadData;
   logic        wbHalt;

   assign memRd     = em.rd;
   assign memResult = em.result;
   assign memValid  = em.valid;
   // Load data is not ready until writeback
   assign memRegWrt = em.ctrl.regWrt && !em.ctrl.memRead;

   assign storeValid = em.valid && em.ctrl.memWrt;
   assign storeAddr  = em.result[`PROC_DMEM_AW-1:0];
   assign storeData  = em.storeData;
   assign loadData   = dmem[storeAddr];

   // Data memory starts out zeroed
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 2**`PROC_DMEM_AW; i++) begin
            dmem[i] <= '0;
         end
      end else if (storeValid) begin
         dmem[storeAddr] <= storeData;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wbValid <= 1'b0;
         halted  <= 1'b0;
      end else begin
         wbValid <= em.valid;
         halted  <= halted || (wbValid && wbHalt);
      end
   end

   always_ff @(posedge clk) begin
      wbRegWrt <= em.ctrl.regWrt;
      wbRd     <= em.rd;
      wbData   <= em.ctrl.memRead ? loadData : em.result;
      wbHalt   <= em.ctrl.halt;
   end

endmodule

`default_nettype wire

// File: src/pipeIfs.sv
`timescale 1ns/1ps
`default_nettype none

interface decodeExecIf;
   logic                 valid;
   procPkg::ctrlT        ctrl;
   logic [2:0]           rs;
   logic [2:0]           rt;
   logic [2:0]           rd;
   logic [15:0]          opA;
   logic [15:0]          opB;
   logic [15:0]          imm;
   logic [15:0]          pcInc;

   modport src (output valid, ctrl, rs, rt, rd, opA, opB, imm, pcInc);
   modport dst (input valid, ctrl, rs, rt, rd, opA, opB, imm, pcInc);
endinterface

interface execMemIf;
   logic          valid;
   procPkg::ctrlT ctrl;
   logic [2:0]    rd;
   // ALU result, or the effective address for loads and stores
   logic [15:0]   result;
   logic [15:0]   storeData;

   modport src (output valid, ctrl, rd, result, storeData);
   modport dst (input valid, ctrl, rd, result, storeData);
endinterface

`default_nettype wire

// File: src/proc.sv
`timescale 1ns/1ps
`default_nettype none
`include "proc_settings.svh"

module proc (
   input  wire                      clk,
   input  wire                      rst,
   input  wire                      imemWrEn,
   input  wire [`PROC_IMEM_AW-1:0]  imemAddr,
   input  wire [15:0]               imemData,
   output wire                      err,
   output wire                      halted,
   output wire                      commitValid,
   output wire [2:0]                commitReg,
   output wire [15:0]               commitData,
   output wire                      storeValid,
   output wire [`PROC_DMEM_AW-1:0]  storeAddr,
   output wire [15:0]               storeData
);

   procPkg::instrT instrD;
   wire [15:0]     pcIncD;
   wire            validD;
   wire            stall;
   wire            redirect;
   wire [15:0]     target;

   wire [2:0]      memRd;
   wire [15:0]     memResult;
   wire            memRegWrt;
   wire            memValid;
   wire            wbValid;
   wire            wbRegWrt;
   wire [2:0]      wbRd;
   wire [15:0]     wbData;

   decodeExecIf dxIf ();
   execMemIf    emIf ();

   fetch fetchStage (
      .clk(clk), .rst(rst), .imemWrEn(imemWrEn), .imemAddr(imemAddr),
      .imemData(imemData), .stall(stall), .halted(halted), .redirect(redirect),
      .target(target), .instrD(instrD), .pcIncD(pcIncD), .validD(validD)
   );

   decode decodeStage (
      .clk(clk), .rst(rst), .instrD(instrD), .pcIncD(pcIncD), .validD(validD),
      .redirect(redirect), .wbValid(wbValid), .wbRegWrt(wbRegWrt), .wbRd(wbRd),
      .wbData(wbData), .stall(stall), .err(err), .dx(dxIf.src)
   );

   execute executeStage (
      .clk(clk), .rst(rst), .dx(dxIf.dst), .memRd(memRd), .memResult(memResult),
      .memRegWrt(memRegWrt), .memValid(memValid), .wbValid(wbValid),
      .wbRegWrt(wbRegWrt), .wbRd(wbRd), .wbData(wbData), .redirect(redirect),
      .target(target), .em(emIf.src)
   );

   memory memoryStage (
      .clk(clk), .rst(rst), .em(emIf.dst), .memRd(memRd), .memResult(memResult),
      .memRegWrt(memRegWrt), .memValid(memValid), .wbValid(wbValid),
      .wbRegWrt(wbRegWrt), .wbRd(wbRd), .wbData(wbData), .storeValid(storeValid),
      .storeAddr(storeAddr), .storeData(storeData), .halted(halted)
   );

   assign commitValid = wbValid & wbRegWrt;
   assign commitReg   = wbRd;
   assign commitData  = wbData;

endmodule

`default_nettype wire

// File: src/procPkg.sv
`default_nettype none

package procPkg;

   typedef enum logic [4:0] {
      opHalt = 5'b00000,
      opAddi = 5'b01000,
      opBeqz = 5'b01100,
      opBnez = 5'b01101,
      opSt   = 5'b10000,
      opLd   = 5'b10001,
      opLbi  = 5'b11000,
      opAlu  = 5'b11011
   } opcodeT;

   typedef enum logic [1:0] {
      aluAdd = 2'b00,
      aluSub = 2'b01,
      aluAnd = 2'b10,
      aluXor = 2'b11
   } aluOpT;

   // One instruction word, three field layouts
   typedef union packed {
      struct packed {
         opcodeT     opcode;
         logic [2:0] rs;
         logic [2:0] rt;
         logic [2:0] rd;
         aluOpT      func;
      } rForm;
      struct packed {
         opcodeT     opcode;
         logic [2:0] rs;
         logic [2:0] rd;
         logic [4:0] imm;
      } iForm;
      struct packed {
         opcodeT     opcode;
         logic [2:0] rs;
         logic [7:0] imm;
      } bForm;
   } instrT;

   typedef struct packed {
      aluOpT aluOp;
      logic  useImm;
      logic  passImm;   // result is the immediate itself (LBI)
      logic  regWrt;
      logic  memRead;
      logic  memWrt;
      logic  branch;
      logic  brNotZero;
      logic  halt;
   } ctrlT;

endpackage

`default_nettype wire

// File: src/proc_settings.svh
`ifndef PROC_SETTINGS_SVH
`define PROC_SETTINGS_SVH

// Instruction memory address width, 64 words
`define PROC_IMEM_AW 6

// Data memory address width, 32 words
`define PROC_DMEM_AW 5

// General purpose registers
`define PROC_NREGS 8

`endif

// File: testbench/tbProc.sv
`timescale 1ns/1ps
`default_nettype none
`include "proc_settings.svh"

module tbProc;

   localparam int ProgLen = 40;

   localparam logic [4:0] codeHalt = 5'b00000;
   localparam logic [4:0] codeAddi = 5'b01000;
   localparam logic [4:0] codeBeqz = 5'b01100;
   localparam logic [4:0] codeBnez = 5'b01101;
   localparam logic [4:0] codeSt   = 5'b10000;
   localparam logic [4:0] codeLd   = 5'b10001;
   localparam logic [4:0] codeLbi  = 5'b11000;
   localparam logic [4:0] codeAlu  = 5'b11011;

   logic                     clk;
   logic                     rst;
   logic                     imemWrEn;
   logic [`PROC_IMEM_AW-1:0] imemAddr;
   logic [15:0]              imemData;
   wire                      err;
   wire                      halted;
   wire                      commitValid;
   wire [2:0]                commitReg;
   wire [15:0]               commitData;
   wire                      storeValid;
   wire [`PROC_DMEM_AW-1:0]  storeAddr;
   wire [15:0]               storeData;

   logic [15:0] prog [ProgLen];
   logic [15:0] mRegs [`PROC_NREGS];
   logic [15:0] mMem [2**`PROC_DMEM_AW];
   // Each event holds a store flag, a register or address and the data
   logic [21:0] expected [$];
   logic [21:0] head;
   int          errors;
   int          commits;
   int          modelCommits;

   proc u_dut (
      .clk(clk), .rst(rst), .imemWrEn(imemWrEn), .imemAddr(imemAddr),
      .imemData(imemData), .err(err), .halted(halted), .commitValid(commitValid),
      .commitReg(commitReg), .commitData(commitData), .storeValid(storeValid),
      .storeAddr(storeAddr), .storeData(storeData)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [2:0] pickReg(input logic [2:0] recent);
      if ($urandom_range(0, 1) == 0) begin
         return recent;
      end
      return 3'($urandom_range(0, 7));
   endfunction

   // Runs one instruction on the model state and returns the next PC or -1 on HALT
   function automatic int refStep(input logic [15:0] ins, input int pc,
                                  output logic [21:0] ev, output logic hasEv);
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] r;
      logic [15:0] immI;
      logic [15:0] immB;
      logic [4:0]  addr;
      logic [5:0]  tgt;
      logic [2:0]  dst;
      logic        writes;
      int          next;
      a      = mRegs[ins[10:8]];
      b      = mRegs[ins[7:5]];
      immI   = {{11{ins[4]}}, ins[4:0]};
      immB   = {{8{ins[7]}}, ins[7:0]};
      addr   = 5'(a + immI);
      tgt    = 6'(pc + 1) + immB[5:0];
      dst    = ins[7:5];
      r      = '0;
      writes = 1'b0;
      ev     = '0;
      hasEv  = 1'b0;
      next   = pc + 1;
      case (ins[15:11])
         codeAlu: begin
            dst    = ins[4:2];
            writes = 1'b1;
            case (ins[1:0])
               2'd0:    r = a + b;
               2'd1:    r = a - b;
               2'd2:    r = a & b;
               default: r = a ^ b;
            endcase
         end
         codeAddi: begin
            r      = a + immI;
            writes = 1'b1;
         end
         codeLbi: begin
            dst    = ins[10:8];
            r      = immB;
            writes = 1'b1;
         end
         codeLd: begin
            r      = mMem[addr];
            writes = 1'b1;
         end
         codeSt: begin
            mMem[addr] = b;
            ev         = {1'b1, addr, b};
            hasEv      = 1'b1;
         end
         codeBeqz: if (a == 16'd0) next = int'(tgt);
         codeBnez: if (a != 16'd0) next = int'(tgt);
         codeHalt: next = -1;
         // Undefined opcodes change nothing
         default: ;
      endcase
      if (writes) begin
         mRegs[dst] = r;
         ev         = {3'b000, dst, r};
         hasEv      = 1'b1;
      end
      return next;
   endfunction

   task automatic genProgram();
      logic [2:0] recent;
      logic [2:0] rd;
      logic       useNext;
      int         kind;
      int         maxOff;
      recent  = 3'd0;
      useNext = 1'b0;
      for (int i = 0; i < ProgLen - 1; i++) begin
         rd   = 3'($urandom_range(0, 7));
         kind = useNext ? 0 : int'($urandom_range(0, 9));
         case (kind)
            3: prog[i] = {codeAddi, pickReg(recent), rd, 5'($urandom)};
            4: prog[i] = {codeLbi, rd, ($urandom_range(0, 2) == 0) ? 8'd0 : 8'($urandom)};
            5: prog[i] = {codeLd, pickReg(recent), rd, 5'($urandom)};
            6: prog[i] = {codeSt, pickReg(recent), pickReg(recent), 5'($urandom)};
            7, 8: begin
               // Forward targets that reach at most the final HALT
               maxOff  = (ProgLen - 2 - i < 6) ? ProgLen - 2 - i : 6;
               prog[i] = {(kind == 7) ? codeBeqz : codeBnez, pickReg(recent),
                          8'($urandom_range(0, maxOff))};
            end
            default: begin
               prog[i] = {codeAlu, useNext ? recent : pickReg(recent), pickReg(recent),
                          rd, 2'($urandom)};
            end
         endcase
         if (kind < 6) begin
            recent = rd;
         end
         useNext = (kind == 5);
      end
      prog[ProgLen-1] = {codeHalt, 11'd0};
   endtask

   task automatic buildExpected(input int n);
      logic [21:0] ev;
      logic        hasEv;
      int          pc;
      int          steps;
      for (int i = 0; i < `PROC_NREGS; i++) begin
         mRegs[i] = '0;
      end
      for (int i = 0; i < 2**`PROC_DMEM_AW; i++) begin
         mMem[i] = '0;
      end
      expected.delete();
      modelCommits = 0;
      pc           = 0;
      steps        = 0;
      while (pc >= 0 && pc < n && steps < 500) begin
         pc = refStep(prog[pc], pc, ev, hasEv);
         if (hasEv) begin
            expected.push_back(ev);
            modelCommits += ev[21] ? 0 : 1;
         end
         steps++;
      end
   endtask

   task automatic checkQuiet(input string when);
      if (commitValid || storeValid || halted || err) begin
         errors++;
         $display("FAILED %s: commitValid=%h storeValid=%h halted=%h err=%h, expected all 0",
                  when, commitValid, storeValid, halted, err);
      end
   endtask

   task automatic loadAndReset(input int n);
      @(negedge clk);
      rst = 1'b1;
      for (int i = 0; i < n; i++) begin
         imemWrEn = 1'b1;
         imemAddr = i[`PROC_IMEM_AW-1:0];
         imemData = prog[i];
         @(negedge clk);
      end
      imemWrEn = 1'b0;
      repeat (4) begin
         @(negedge clk);
         checkQuiet("during reset");
      end
      rst = 1'b0;
      @(negedge clk);
      checkQuiet("after reset");
   endtask

   task automatic waitErr(input int limit);
      int n;
      n = 0;
      while (!err && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (!err) begin
         errors++;
         $display("Timeout: err did not rise within %0d cycles", limit);
      end
   endtask

   task automatic waitHalted(input logic errLevel, input int limit);
      int n;
      n = 0;
      while (!halted && n < limit) begin
         @(negedge clk);
         if (err !== errLevel) begin
            errors++;
            $display("FAILED err: got %h expected %h", err, errLevel);
         end
         n++;
      end
      if (!halted) begin
         errors++;
         $display("Timeout: halted did not rise within %0d cycles", limit);
      end
   endtask

   task automatic watchAfterHalt(input logic errLevel);
      repeat (20) begin
         @(negedge clk);
         if (!halted || err !== errLevel) begin
            errors++;
            $display("FAILED halted/err: got %h/%h expected 1/%h", halted, err, errLevel);
         end
      end
      if (expected.size() != 0) begin
         errors++;
         $display("%0d expected events never appeared", expected.size());
      end
      if (commits != modelCommits) begin
         errors++;
         $display("FAILED commit count: got %h expected %h", commits, modelCommits);
      end
   endtask

   // Commits are older than a store seen in the same cycle
   always @(negedge clk) begin
      if (commitValid) begin
         commits++;
         if (expected.size() == 0 || expected[0][21]) begin
            errors++;
            $display("Commit to r%0d arrived when none was expected", commitReg);
         end else begin
            head = expected.pop_front();
            if (commitReg !== head[18:16] || commitData !== head[15:0]) begin
               errors++;
               $display("FAILED commitReg/commitData: got %h/%h expected %h/%h",
                        commitReg, commitData, head[18:16], head[15:0]);
            end
         end
      end
      if (storeValid) begin
         if (expected.size() == 0 || !expected[0][21]) begin
            errors++;
            $display("Store to address %0d arrived when none was expected", storeAddr);
         end else begin
            head = expected.pop_front();
            if (storeAddr !== head[20:16] || storeData !== head[15:0]) begin
               errors++;
               $display("FAILED storeAddr/storeData: got %h/%h expected %h/%h",
                        storeAddr, storeData, head[20:16], head[15:0]);
            end
         end
      end
   end

   initial begin
      void'($urandom(35216));
      rst      = 1'b1;
      imemWrEn = 1'b0;
      imemAddr = '0;
      imemData = '0;
      errors   = 0;
      commits  = 0;
      genProgram();
      buildExpected(ProgLen);
      loadAndReset(ProgLen);
      waitHalted(1'b0, 400);
      watchAfterHalt(1'b0);

      // Second run with an undefined opcode at address 2
      prog[0] = {codeLbi, 3'd1, 8'd7};
      prog[1] = {codeLbi, 3'd2, 8'd3};
      prog[2] = {5'b11111, 11'd0};
      prog[3] = {codeAlu, 3'd1, 3'd2, 3'd3, 2'd0};
      prog[4] = {codeHalt, 11'd0};
      buildExpected(5);
      commits = 0;
      loadAndReset(5);
      waitErr(50);
      waitHalted(1'b1, 50);
      watchAfterHalt(1'b1);

      $display("Errors: %0d, commits in last run: %0d", errors, commits);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
